// ==== src.f ====
+incdir+rtl
rtl/timeFormatPkg.sv
rtl/regMapPkg.sv
rtl/eventCapture.sv
rtl/delayCompensator.sv
rtl/timestampRegs.sv
rtl/signalTimestamper.sv
verification/signalTimestamper_assertions.sv
verification/tbSignalTimestamper.sv

// ==== Bender.yml ====
package:
  name: signal_timestamper

export_include_dirs:
  - rtl

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/timeFormatPkg.sv
      - rtl/regMapPkg.sv
      - rtl/eventCapture.sv
      - rtl/delayCompensator.sv
      - rtl/timestampRegs.sv
      - rtl/signalTimestamper.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - verification/signalTimestamper_assertions.sv
      - verification/tbSignalTimestamper.sv

// ==== verification/tbSignalTimestamper.sv ====
// ********************
// signal timestamper testbench
// drives events and clock time, checks the AXI register view
// ********************
`default_nettype none
`include "timestamper_consts.svh"

module tbSignalTimestamper;

  timeunit 1ns;
  timeprecision 1ps;

  import timeFormatPkg::*;
  import regMapPkg::*;

  localparam int AxiTimeout = 16;
  localparam int IrqTimeout = 12;

  logic                          SysClk_ClkIn;
  logic                          SysRstN_RstIn;
  secondT                        ClockTimeSecond;
  nanosecondT                    ClockTimeNanosecond;
  logic                          ClockTimeValid;
  logic                          SignalEvent;
  logic                          Irq;
  logic                          AxiAwValid;
  logic                          AxiAwReady;
  logic [`TS_AXI_ADDR_WIDTH-1:0] AxiAwAddr;
  logic                          AxiWValid;
  logic                          AxiWReady;
  logic [`TS_AXI_DATA_WIDTH-1:0] AxiWData;
  logic                          AxiBValid;
  logic                          AxiBReady;
  axiRespT                       AxiBResp;
  logic                          AxiArValid;
  logic                          AxiArReady;
  logic [`TS_AXI_ADDR_WIDTH-1:0] AxiArAddr;
  logic                          AxiRValid;
  logic                          AxiRReady;
  axiRespT                       AxiRResp;
  logic [`TS_AXI_DATA_WIDTH-1:0] AxiRData;

  int          valueErrors = 0;
  int          timeoutErrors = 0;
  logic [63:0] expStampQ[$];
  logic [63:0] gotStampQ[$];

  signalTimestamper signalTimestamper_inst (.*);

  always #10 SysClk_ClkIn = ~SysClk_ClkIn;

  // time minus input, synchronizer and cable delay, borrowing a second
  function automatic logic [63:0] expectedStamp(input secondT sec, input nanosecondT ns,
                                                input cableDelayT cable);
    logic [31:0] delayNs;
    secondT      outSec;
    nanosecondT  outNs;
    delayNs = `TS_INPUT_DELAY_NS + `TS_SYNC_CYCLES * `TS_CLOCK_PERIOD_NS + 32'(cable);
    if (ns < delayNs) begin
      outSec = sec - 32'd1;
      outNs  = ns + `TS_NS_PER_SECOND - delayNs;
    end else begin
      outSec = sec;
      outNs  = ns - delayNs;
    end
    return {outSec, outNs};
  endfunction

  // ********************
  // timestamp compare
  // ********************
  always @(negedge SysClk_ClkIn) begin
    logic [63:0] gotStamp;
    logic [63:0] expStamp;
    if (gotStampQ.size() != 0 && expStampQ.size() != 0) begin
      gotStamp = gotStampQ.pop_front();
      expStamp = expStampQ.pop_front();
      assert (gotStamp[31:0] === expStamp[31:0]) else begin
        valueErrors++;
        $display("error TimeLow got 0x%08h expected 0x%08h", gotStamp[31:0], expStamp[31:0]);
      end
      assert (gotStamp[63:32] === expStamp[63:32]) else begin
        valueErrors++;
        $display("error TimeHigh got 0x%08h expected 0x%08h", gotStamp[63:32], expStamp[63:32]);
      end
    end
  end

  // ********************
  // AXI master tasks
  // ********************
  task automatic axiWrite(input logic [15:0] addr, input logic [31:0] data,
                          input axiRespT expResp);
    int waitCycles;
    @(negedge SysClk_ClkIn);
    AxiAwAddr  = addr;
    AxiWData   = data;
    AxiAwValid = 1'b1;
    AxiWValid  = 1'b1;
    waitCycles = 0;
    while (AxiAwReady !== 1'b1 && waitCycles < AxiTimeout) begin
      @(negedge SysClk_ClkIn);
      waitCycles++;
    end
    assert (AxiAwReady === 1'b1) else begin
      timeoutErrors++;
      $display("timeout: write to 0x%04h was never accepted", addr);
    end
    assert (AxiWReady === 1'b1) else begin
      valueErrors++;
      $display("error AxiWReady at 0x%04h got 0x%01h expected 0x1", addr, AxiWReady);
    end
    AxiAwValid = 1'b0;
    AxiWValid  = 1'b0;
    waitCycles = 0;
    while (AxiBValid !== 1'b1 && waitCycles < AxiTimeout) begin
      @(negedge SysClk_ClkIn);
      waitCycles++;
    end
    assert (AxiBValid === 1'b1) else begin
      timeoutErrors++;
      $display("timeout: no write response for 0x%04h", addr);
    end
    assert (AxiBResp === expResp) else begin
      valueErrors++;
      $display("error AxiBResp at 0x%04h got 0x%01h expected 0x%01h", addr, AxiBResp, expResp);
    end
    // response held back one cycle, BValid has to stay up meanwhile
    @(negedge SysClk_ClkIn);
    AxiBReady = 1'b1;
    @(negedge SysClk_ClkIn);
    AxiBReady = 1'b0;
  endtask

  task automatic axiRead(input logic [15:0] addr, output logic [31:0] data,
                         output axiRespT resp);
    int waitCycles;
    @(negedge SysClk_ClkIn);
    AxiArAddr  = addr;
    AxiArValid = 1'b1;
    waitCycles = 0;
    while (AxiArReady !== 1'b1 && waitCycles < AxiTimeout) begin
      @(negedge SysClk_ClkIn);
      waitCycles++;
    end
    assert (AxiArReady === 1'b1) else begin
      timeoutErrors++;
      $display("timeout: read of 0x%04h was never accepted", addr);
    end
    AxiArValid = 1'b0;
    waitCycles = 0;
    while (AxiRValid !== 1'b1 && waitCycles < AxiTimeout) begin
      @(negedge SysClk_ClkIn);
      waitCycles++;
    end
    assert (AxiRValid === 1'b1) else begin
      timeoutErrors++;
      $display("timeout: read of 0x%04h got no data", addr);
    end
    data = AxiRData;
    resp = AxiRResp;
    // data held back one cycle, RValid has to stay up meanwhile
    @(negedge SysClk_ClkIn);
    AxiRReady = 1'b1;
    @(negedge SysClk_ClkIn);
    AxiRReady = 1'b0;
  endtask

  task automatic checkRead(input string regName, input logic [15:0] addr,
                           input logic [31:0] expData, input axiRespT expResp);
    logic [31:0] data;
    axiRespT     resp;
    axiRead(addr, data, resp);
    assert (data === expData) else begin
      valueErrors++;
      $display("error AxiRData %s got 0x%08h expected 0x%08h", regName, data, expData);
    end
    assert (resp === expResp) else begin
      valueErrors++;
      $display("error AxiRResp %s got 0x%01h expected 0x%01h", regName, resp, expResp);
    end
  endtask

  // ********************
  // event helpers
  // ********************
  task automatic waitForIrq();
    int waitCycles;
    waitCycles = 0;
    while (Irq !== 1'b1 && waitCycles < IrqTimeout) begin
      @(negedge SysClk_ClkIn);
      waitCycles++;
    end
    assert (Irq === 1'b1) else begin
      timeoutErrors++;
      $display("timeout: Irq did not rise after the event");
    end
  endtask

  // the pipeline answers within 6 cycles, so a quiet window proves no interrupt
  task automatic expectNoIrq(input int cycles);
    bit seenHigh;
    seenHigh = 1'b0;
    repeat (cycles) begin
      @(negedge SysClk_ClkIn);
      if (Irq !== 1'b0 && !seenHigh) begin
        seenHigh = 1'b1;
        assert (Irq === 1'b0) else begin
          valueErrors++;
          $display("error Irq got 0x%01h expected 0x0", Irq);
        end
      end
    end
  endtask

  task automatic pulseEvent(input logic activeLevel);
    @(negedge SysClk_ClkIn);
    SignalEvent = activeLevel;
    repeat (10) @(negedge SysClk_ClkIn);
    SignalEvent = ~activeLevel;
    repeat (4) @(negedge SysClk_ClkIn);
  endtask

  task automatic timestampOne(input secondT sec, input nanosecondT ns,
                              input cableDelayT cable, input logic activeLevel);
    logic [31:0] lowWord;
    logic [31:0] highWord;
    axiRespT     resp;
    axiWrite(RegCableDelay, 32'(cable), RespOkay);
    @(negedge SysClk_ClkIn);
    // time held steady until the next event
    ClockTimeSecond     = sec;
    ClockTimeNanosecond = ns;
    ClockTimeValid      = 1'b1;
    expStampQ.push_back(expectedStamp(sec, ns, cable));
    SignalEvent = activeLevel;
    waitForIrq();
    axiRead(RegTimeLow, lowWord, resp);
    axiRead(RegTimeHigh, highWord, resp);
    gotStampQ.push_back({highWord, lowWord});
    SignalEvent = ~activeLevel;
    repeat (4) @(negedge SysClk_ClkIn);
  endtask

  // ********************
  // main sequence
  // ********************
  initial begin
    int         seedValue;
    int         waitCycles;
    secondT     sec;
    nanosecondT ns;
    cableDelayT cable;
    SysClk_ClkIn        = 1'b0;
    SysRstN_RstIn       = 1'b0;
    ClockTimeSecond     = '0;
    ClockTimeNanosecond = '0;
    ClockTimeValid      = 1'b0;
    SignalEvent         = 1'b0;
    AxiAwValid          = 1'b0;
    AxiAwAddr           = '0;
    AxiWValid           = 1'b0;
    AxiWData            = '0;
    AxiBReady           = 1'b0;
    AxiArValid          = 1'b0;
    AxiArAddr           = '0;
    AxiRReady           = 1'b0;
    seedValue = 32'h0ce20420;
    void'($urandom(seedValue));
    repeat (8) @(posedge SysClk_ClkIn);
    @(negedge SysClk_ClkIn);
    SysRstN_RstIn = 1'b1;

    // reset values and decode errors
    checkRead("version", RegVersion, `TS_VERSION, RespOkay);
    checkRead("polarity", RegPolarity, 32'h1, RespOkay);
    checkRead("control", RegControl, 32'h0, RespOkay);
    checkRead("irq", RegIrq, 32'h0, RespOkay);
    checkRead("event count", RegEvtCount, 32'h0, RespOkay);
    checkRead("sequence", RegCount, 32'h0, RespOkay);
    checkRead("unmapped 0x0010", 16'h0010, 32'h0, RespSlvErr);
    axiWrite(RegVersion, 32'h1, RespSlvErr);

    // random times, odd rounds force a second borrow
    axiWrite(RegControl, 32'h1, RespOkay);
    axiWrite(RegIrqMask, 32'h1, RespOkay);
    for (int i = 0; i < 6; i++) begin
      cable = cableDelayT'($urandom);
      sec   = $urandom;
      if (i % 2 == 1) begin
        ns = $urandom % (`TS_INPUT_DELAY_NS + `TS_SYNC_CYCLES * `TS_CLOCK_PERIOD_NS
                         + 32'(cable));
      end else begin
        ns = $urandom % `TS_NS_PER_SECOND;
      end
      timestampOne(sec, ns, cable, 1'b1);
      axiWrite(RegIrq, 32'h1, RespOkay);
    end

    // active low, switched while disabled to avoid a spurious edge
    axiWrite(RegControl, 32'h0, RespOkay);
    axiWrite(RegPolarity, 32'h0, RespOkay);
    repeat (4) @(negedge SysClk_ClkIn);
    axiWrite(RegControl, 32'h1, RespOkay);
    @(negedge SysClk_ClkIn);
    SignalEvent = 1'b1;
    expectNoIrq(10);
    checkRead("event count", RegEvtCount, 32'h0, RespOkay);
    timestampOne($urandom, $urandom % `TS_NS_PER_SECOND, cableDelayT'($urandom), 1'b0);
    axiWrite(RegIrq, 32'h1, RespOkay);
    axiWrite(RegControl, 32'h0, RespOkay);
    axiWrite(RegPolarity, 32'h1, RespOkay);
    @(negedge SysClk_ClkIn);
    SignalEvent = 1'b0;
    repeat (4) @(negedge SysClk_ClkIn);
    axiWrite(RegControl, 32'h1, RespOkay);

    // second event while the first is pending
    sec = $urandom;
    ns  = $urandom % `TS_NS_PER_SECOND;
    timestampOne(sec, ns, 16'd0, 1'b1);
    @(negedge SysClk_ClkIn);
    ClockTimeSecond     = $urandom;
    ClockTimeNanosecond = $urandom % `TS_NS_PER_SECOND;
    pulseEvent(1'b1);
    checkRead("status", RegStatus, 32'h1, RespOkay);
    checkRead("event count", RegEvtCount, 32'h2, RespOkay);
    checkRead("sequence", RegCount, 32'h1, RespOkay);
    checkRead("time low", RegTimeLow, expectedStamp(sec, ns, 16'd0) & 64'hFFFFFFFF, RespOkay);
    checkRead("time high", RegTimeHigh, expectedStamp(sec, ns, 16'd0) >> 32, RespOkay);
    axiWrite(RegIrq, 32'h1, RespOkay);
    expectNoIrq(1);

    // masked interrupt, then disable clears everything
    axiWrite(RegIrqMask, 32'h0, RespOkay);
    fork
      pulseEvent(1'b1);
      expectNoIrq(14);
    join
    checkRead("irq", RegIrq, 32'h1, RespOkay);
    axiWrite(RegControl, 32'h0, RespOkay);
    checkRead("event count", RegEvtCount, 32'h0, RespOkay);
    checkRead("sequence", RegCount, 32'h0, RespOkay);
    checkRead("irq", RegIrq, 32'h0, RespOkay);
    checkRead("status", RegStatus, 32'h0, RespOkay);

    // invalid clock time gives no timestamp
    axiWrite(RegControl, 32'h1, RespOkay);
    axiWrite(RegIrqMask, 32'h1, RespOkay);
    @(negedge SysClk_ClkIn);
    ClockTimeValid = 1'b0;
    fork
      pulseEvent(1'b1);
      expectNoIrq(14);
    join
    checkRead("irq", RegIrq, 32'h0, RespOkay);

    waitCycles = 0;
    while (gotStampQ.size() != 0 && waitCycles < AxiTimeout) begin
      @(negedge SysClk_ClkIn);
      waitCycles++;
    end
    assert (gotStampQ.size() == 0) else begin
      timeoutErrors++;
      $display("timeout: timestamp compare queue did not drain");
    end
    $display("summary: value errors %0d, timeouts %0d, assertion failures %0d",
             valueErrors, timeoutErrors,
             signalTimestamper_inst.timestampRegs_inst.signalTimestamperAssertions_inst.assertFailures);
    if (valueErrors == 0 && timeoutErrors == 0 &&
        signalTimestamper_inst.timestampRegs_inst.signalTimestamperAssertions_inst.assertFailures
        == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== verification/signalTimestamper_assertions.sv ====
// ********************
// register file assertions
// AXI response hold, strobe width and reset state
// ********************
`default_nettype none

module signalTimestamperAssertions (
  input wire SysClk_ClkIn,
  input wire SysRstN_RstIn,
  input wire AxiAwReady,
  input wire AxiWReady,
  input wire AxiArReady,
  input wire AxiBValid,
  input wire AxiBReady,
  input wire AxiRValid,
  input wire AxiRReady,
  input wire TimestampStrobe
);

  timeunit 1ns;
  timeprecision 1ps;

  int assertFailures = 0;

  bValidHeld: assert property (@(posedge SysClk_ClkIn) disable iff (!SysRstN_RstIn)
    AxiBValid && !AxiBReady |=> AxiBValid)
    else begin
      assertFailures++;
      $error("BValid dropped before BReady");
    end

  rValidHeld: assert property (@(posedge SysClk_ClkIn) disable iff (!SysRstN_RstIn)
    AxiRValid && !AxiRReady |=> AxiRValid)
    else begin
      assertFailures++;
      $error("RValid dropped before RReady");
    end

  // one timestamp per strobe
  strobeSingle: assert property (@(posedge SysClk_ClkIn) disable iff (!SysRstN_RstIn)
    TimestampStrobe |=> !TimestampStrobe)
    else begin
      assertFailures++;
      $error("TimestampStrobe longer than one cycle");
    end

  readiesLowAfterReset: assert property (@(posedge SysClk_ClkIn)
    $rose(SysRstN_RstIn) |-> !AxiAwReady && !AxiWReady && !AxiArReady)
    else begin
      assertFailures++;
      $error("AXI readies high when leaving reset");
    end

endmodule

bind timestampRegs signalTimestamperAssertions signalTimestamperAssertions_inst (
  .SysClk_ClkIn    (SysClk_ClkIn),
  .SysRstN_RstIn   (SysRstN_RstIn),
  .AxiAwReady      (AxiAwReady),
  .AxiWReady       (AxiWReady),
  .AxiArReady      (AxiArReady),
  .AxiBValid       (AxiBValid),
  .AxiBReady       (AxiBReady),
  .AxiRValid       (AxiRValid),
  .AxiRReady       (AxiRReady),
  .TimestampStrobe (TimestampStrobe)
);

`default_nettype wire

// ==== rtl/signalTimestamper.sv ====
// ********************
// signal timestamper top level
// capture, delay compensation and AXI register file
// ********************
`default_nettype none
`include "timestamper_consts.svh"

module signalTimestamper (
  input  wire                            SysClk_ClkIn,
  input  wire                            SysRstN_RstIn,
  input  wire timeFormatPkg::secondT     ClockTimeSecond,
  input  wire timeFormatPkg::nanosecondT ClockTimeNanosecond,
  input  wire                            ClockTimeValid,
  input  wire                            SignalEvent,
  output logic                           Irq,
  input  wire                            AxiAwValid,
  output logic                           AxiAwReady,
  input  wire [`TS_AXI_ADDR_WIDTH-1:0]   AxiAwAddr,
  input  wire                            AxiWValid,
  output logic                           AxiWReady,
  input  wire [`TS_AXI_DATA_WIDTH-1:0]   AxiWData,
  output logic                           AxiBValid,
  input  wire                            AxiBReady,
  output regMapPkg::axiRespT             AxiBResp,
  input  wire                            AxiArValid,
  output logic                           AxiArReady,
  input  wire [`TS_AXI_ADDR_WIDTH-1:0]   AxiArAddr,
  output logic                           AxiRValid,
  input  wire                            AxiRReady,
  output regMapPkg::axiRespT             AxiRResp,
  output logic [`TS_AXI_DATA_WIDTH-1:0]  AxiRData
);

  import timeFormatPkg::*;

  logic        edgeStrobe;
  secondT      capturedSecond;
  nanosecondT  capturedNanosecond;
  logic        capturedValid;
  logic        timestampStrobe;
  secondT      timestampSecond;
  nanosecondT  timestampNanosecond;
  logic [31:0] eventCount;
  logic        enable;
  logic        polarity;
  cableDelayT  cableDelay;

  eventCapture eventCapture_inst (
    .SysClk_ClkIn        (SysClk_ClkIn),
    .SysRstN_RstIn       (SysRstN_RstIn),
    .SignalEvent         (SignalEvent),
    .Polarity            (polarity),
    .Enable              (enable),
    .ClockTimeSecond     (ClockTimeSecond),
    .ClockTimeNanosecond (ClockTimeNanosecond),
    .ClockTimeValid      (ClockTimeValid),
    .EdgeStrobe          (edgeStrobe),
    .CapturedSecond      (capturedSecond),
    .CapturedNanosecond  (capturedNanosecond),
    .CapturedValid       (capturedValid)
  );

  delayCompensator delayCompensator_inst (
    .SysClk_ClkIn        (SysClk_ClkIn),
    .SysRstN_RstIn       (SysRstN_RstIn),
    .EdgeStrobe          (edgeStrobe),
    .CapturedSecond      (capturedSecond),
    .CapturedNanosecond  (capturedNanosecond),
    .CapturedValid       (capturedValid),
    .CableDelay          (cableDelay),
    .Enable              (enable),
    .TimestampStrobe     (timestampStrobe),
    .TimestampSecond     (timestampSecond),
    .TimestampNanosecond (timestampNanosecond),
    .EventCount          (eventCount)
  );

  timestampRegs timestampRegs_inst (
    .SysClk_ClkIn        (SysClk_ClkIn),
    .SysRstN_RstIn       (SysRstN_RstIn),
    .AxiAwValid          (AxiAwValid),
    .AxiAwReady          (AxiAwReady),
    .AxiAwAddr           (AxiAwAddr),
    .AxiWValid           (AxiWValid),
    .AxiWReady           (AxiWReady),
    .AxiWData            (AxiWData),
    .AxiBValid           (AxiBValid),
    .AxiBReady           (AxiBReady),
    .AxiBResp            (AxiBResp),
    .AxiArValid          (AxiArValid),
    .AxiArReady          (AxiArReady),
    .AxiArAddr           (AxiArAddr),
    .AxiRValid           (AxiRValid),
    .AxiRReady           (AxiRReady),
    .AxiRResp            (AxiRResp),
    .AxiRData            (AxiRData),
    .TimestampStrobe     (timestampStrobe),
    .TimestampSecond     (timestampSecond),
    .TimestampNanosecond (timestampNanosecond),
    .EventCount          (eventCount),
    .Enable              (enable),
    .Polarity            (polarity),
    .CableDelay          (cableDelay),
    .Irq                 (Irq)
  );

endmodule

`default_nettype wire

// ==== rtl/timestampRegs.sv ====
// ********************
// timestamper register file
// AXI4-Lite slave with control, interrupt and drop logic,
// latches incoming timestamps
// ********************
`default_nettype none
`include "timestamper_consts.svh"

module timestampRegs (
  input  wire                                SysClk_ClkIn,
  input  wire                                SysRstN_RstIn,
  input  wire                                AxiAwValid,
  output logic                               AxiAwReady,
  input  wire [`TS_AXI_ADDR_WIDTH-1:0]       AxiAwAddr,
  input  wire                                AxiWValid,
  output logic                               AxiWReady,
  input  wire [`TS_AXI_DATA_WIDTH-1:0]       AxiWData,
  output logic                               AxiBValid,
  input  wire                                AxiBReady,
  output regMapPkg::axiRespT                 AxiBResp,
  input  wire                                AxiArValid,
  output logic                               AxiArReady,
  input  wire [`TS_AXI_ADDR_WIDTH-1:0]       AxiArAddr,
  output logic                               AxiRValid,
  input  wire                                AxiRReady,
  output regMapPkg::axiRespT                 AxiRResp,
  output logic [`TS_AXI_DATA_WIDTH-1:0]      AxiRData,
  input  wire                                TimestampStrobe,
  input  wire timeFormatPkg::secondT         TimestampSecond,
  input  wire timeFormatPkg::nanosecondT     TimestampNanosecond,
  input  wire [31:0]                         EventCount,
  output logic                               Enable,
  output logic                               Polarity,
  output timeFormatPkg::cableDelayT          CableDelay,
  output logic                               Irq
);

  import timeFormatPkg::*;
  import regMapPkg::*;

  axiStateT                      accessState;
  logic [`TS_AXI_DATA_WIDTH-1:0] wrMask;
  logic [`TS_AXI_DATA_WIDTH-1:0] wrData;
  logic                          wrError;
  logic [`TS_AXI_DATA_WIDTH-1:0] rdData;
  logic                          rdError;
  logic                          writeFire;

  logic        irqFlag;
  logic        irqMask;
  logic        dropFlag;
  logic [31:0] evtCountReg;
  logic [31:0] seqCountReg;
  nanosecondT  timeLowReg;
  secondT      timeHighReg;

  assign Irq       = irqFlag & irqMask;
  // readies are only high in the write state, valids are held by the master
  assign writeFire = accessState == AccessWrite;
  assign wrData    = AxiWData & wrMask;

  // ********************
  // address decode
  // ********************
  always_comb begin
    wrMask  = `TS_MASK_SINGLE_BIT;
    wrError = 1'b0;
    case (regAddrT'(AxiAwAddr))
      RegControl, RegStatus, RegPolarity, RegIrq, RegIrqMask: wrMask = `TS_MASK_SINGLE_BIT;
      RegCableDelay: wrMask = `TS_MASK_CABLE_DELAY;
      default: begin
        // read-only or unmapped
        wrMask  = '0;
        wrError = 1'b1;
      end
    endcase
  end

  always_comb begin
    rdData  = '0;
    rdError = 1'b0;
    case (regAddrT'(AxiArAddr))
      RegControl:    rdData = `TS_AXI_DATA_WIDTH'(Enable);
      RegStatus:     rdData = `TS_AXI_DATA_WIDTH'(dropFlag);
      RegPolarity:   rdData = `TS_AXI_DATA_WIDTH'(Polarity);
      RegVersion:    rdData = `TS_VERSION;
      RegCableDelay: rdData = `TS_AXI_DATA_WIDTH'(CableDelay);
      RegIrq:        rdData = `TS_AXI_DATA_WIDTH'(irqFlag);
      RegIrqMask:    rdData = `TS_AXI_DATA_WIDTH'(irqMask);
      RegEvtCount:   rdData = evtCountReg;
      RegCount:      rdData = seqCountReg;
      RegTimeLow:    rdData = timeLowReg;
      RegTimeHigh:   rdData = timeHighReg;
      default:       rdError = 1'b1;
    endcase
  end

  // ********************
  // AXI handshake FSM
  // ********************
  always_ff @(posedge SysClk_ClkIn or negedge SysRstN_RstIn) begin
    if (!SysRstN_RstIn) begin
      accessState <= AccessIdle;
      AxiAwReady  <= 1'b0;
      AxiWReady   <= 1'b0;
      AxiBValid   <= 1'b0;
      AxiBResp    <= RespOkay;
      AxiArReady  <= 1'b0;
      AxiRValid   <= 1'b0;
      AxiRResp    <= RespOkay;
      AxiRData    <= '0;
    end else begin
      case (accessState)
        AccessIdle: begin
          // writes take priority when both arrive together
          if (AxiAwValid && AxiWValid) begin
            AxiAwReady  <= 1'b1;
            AxiWReady   <= 1'b1;
            accessState <= AccessWrite;
          end else if (AxiArValid) begin
            AxiArReady  <= 1'b1;
            accessState <= AccessRead;
          end
        end
        AccessWrite: begin
          AxiAwReady  <= 1'b0;
          AxiWReady   <= 1'b0;
          AxiBValid   <= 1'b1;
          AxiBResp    <= wrError ? RespSlvErr : RespOkay;
          accessState <= AccessRespond;
        end
        AccessRead: begin
          AxiArReady  <= 1'b0;
          AxiRValid   <= 1'b1;
          AxiRResp    <= rdError ? RespSlvErr : RespOkay;
          AxiRData    <= rdData;
          accessState <= AccessRespond;
        end
        AccessRespond: begin
          if ((AxiBValid && AxiBReady) || (AxiRValid && AxiRReady)) begin
            AxiBValid   <= 1'b0;
            AxiRValid   <= 1'b0;
            accessState <= AccessIdle;
          end
        end
        default: accessState <= AccessIdle;
      endcase
    end
  end

  // ********************
  // register file
  // ********************
  always_ff @(posedge SysClk_ClkIn or negedge SysRstN_RstIn) begin
    if (!SysRstN_RstIn) begin
      Enable      <= 1'b0;
      Polarity    <= 1'b1;
      CableDelay  <= '0;
      irqFlag     <= 1'b0;
      irqMask     <= 1'b0;
      dropFlag    <= 1'b0;
      evtCountReg <= '0;
      seqCountReg <= '0;
      timeLowReg  <= '0;
      timeHighReg <= '0;
    end else begin
      if (writeFire) begin
        case (regAddrT'(AxiAwAddr))
          RegControl:    Enable <= wrData[0];
          RegPolarity:   Polarity <= wrData[0];
          RegCableDelay: CableDelay <= wrData[`TS_CABLE_DELAY_WIDTH-1:0];
          RegIrqMask:    irqMask <= wrData[0];
          // flags clear on writing 1
          RegStatus:     dropFlag <= dropFlag & ~wrData[0];
          RegIrq:        irqFlag <= irqFlag & ~wrData[0];
          default: ;
        endcase
      end
      if (TimestampStrobe) begin
        evtCountReg <= evtCountReg + 1'b1;
        if (!irqFlag) begin
          irqFlag     <= 1'b1;
          seqCountReg <= EventCount;
          timeLowReg  <= TimestampNanosecond;
          timeHighReg <= TimestampSecond;
        end else begin
          // previous timestamp not yet read, this one is lost
          dropFlag <= 1'b1;
        end
      end
      if (!Enable) begin
        irqFlag     <= 1'b0;
        dropFlag    <= 1'b0;
        evtCountReg <= '0;
        seqCountReg <= '0;
      end
    end
  end

endmodule

`default_nettype wire

// ==== rtl/delayCompensator.sv ====
// ********************
// delay compensator
// removes input, synchronizer and cable delay from the
// captured time and counts events
// ********************
`default_nettype none
`include "timestamper_consts.svh"

module delayCompensator (
  input  wire                            SysClk_ClkIn,
  input  wire                            SysRstN_RstIn,
  input  wire                            EdgeStrobe,
  input  wire timeFormatPkg::secondT     CapturedSecond,
  input  wire timeFormatPkg::nanosecondT CapturedNanosecond,
  input  wire                            CapturedValid,
  input  wire timeFormatPkg::cableDelayT CableDelay,
  input  wire                            Enable,
  output logic                           TimestampStrobe,
  output timeFormatPkg::secondT          TimestampSecond,
  output timeFormatPkg::nanosecondT      TimestampNanosecond,
  output logic [31:0]                    EventCount
);

  import timeFormatPkg::*;

  nanosecondT totalDelay;
  logic       underflow;

  // fixed part is 100 ns input plus 3 cycles of 20 ns
  assign totalDelay = nanosecondT'(`TS_INPUT_DELAY_NS + `TS_SYNC_CYCLES * `TS_CLOCK_PERIOD_NS)
                    + nanosecondT'(CableDelay);
  assign underflow  = CapturedNanosecond < totalDelay;

  // ********************
  // strobe and event counter
  // ********************
  always_ff @(posedge SysClk_ClkIn or negedge SysRstN_RstIn) begin
    if (!SysRstN_RstIn) begin
      TimestampStrobe <= 1'b0;
      EventCount      <= '0;
    end else if (!Enable) begin
      TimestampStrobe <= 1'b0;
      EventCount      <= '0;
    end else begin
      // an invalid clock time still counts but gives no timestamp
      TimestampStrobe <= EdgeStrobe && CapturedValid;
      if (EdgeStrobe) begin
        EventCount <= EventCount + 1'b1;
      end
    end
  end

  // ********************
  // corrected time
  // ********************
  always_ff @(posedge SysClk_ClkIn) begin
    if (!Enable || (EdgeStrobe && !CapturedValid)) begin
      TimestampSecond     <= '0;
      TimestampNanosecond <= '0;
    end else if (EdgeStrobe) begin
      if (underflow) begin
        // borrow one second
        TimestampSecond     <= CapturedSecond - 1'b1;
        TimestampNanosecond <= CapturedNanosecond + `TS_NS_PER_SECOND - totalDelay;
      end else begin
        TimestampSecond     <= CapturedSecond;
        TimestampNanosecond <= CapturedNanosecond - totalDelay;
      end
    end
  end

endmodule

`default_nettype wire

// ==== rtl/eventCapture.sv ====
// ********************
// event capture
// synchronizes the event, applies polarity, finds the edge
// and samples the running clock time on it
// ********************
`default_nettype none

module eventCapture (
  input  wire                            SysClk_ClkIn,
  input  wire                            SysRstN_RstIn,
  input  wire                            SignalEvent,
  input  wire                            Polarity,
  input  wire                            Enable,
  input  wire timeFormatPkg::secondT     ClockTimeSecond,
  input  wire timeFormatPkg::nanosecondT ClockTimeNanosecond,
  input  wire                            ClockTimeValid,
  output logic                           EdgeStrobe,
  output timeFormatPkg::secondT          CapturedSecond,
  output timeFormatPkg::nanosecondT      CapturedNanosecond,
  output logic                           CapturedValid
);

  logic       polarEvent;
  // two sync flops, then the previous level for the edge detector
  logic [2:0] syncChain;
  logic       edgeSeen;

  // active low events are inverted so only rising edges matter below
  assign polarEvent = Polarity ? SignalEvent : ~SignalEvent;
  assign edgeSeen   = Enable && syncChain[1] && !syncChain[2];

  always_ff @(posedge SysClk_ClkIn or negedge SysRstN_RstIn) begin
    if (!SysRstN_RstIn) begin
      syncChain  <= '0;
      EdgeStrobe <= 1'b0;
    end else begin
      syncChain  <= {syncChain[1:0], polarEvent};
      EdgeStrobe <= edgeSeen;
    end
  end

  // time sample, held until the next edge
  always_ff @(posedge SysClk_ClkIn) begin
    if (edgeSeen) begin
      CapturedSecond     <= ClockTimeSecond;
      CapturedNanosecond <= ClockTimeNanosecond;
      CapturedValid      <= ClockTimeValid;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/regMapPkg.sv ====
// ********************
// register map types
// AXI access states, register offsets and responses
// ********************
`default_nettype none
`include "timestamper_consts.svh"

package regMapPkg;

  // AXI4-Lite slave access FSM
  typedef enum logic [1:0] {
    AccessIdle,
    AccessRead,
    AccessWrite,
    AccessRespond
  } axiStateT;

  typedef enum logic [`TS_AXI_ADDR_WIDTH-1:0] {
    RegControl    = `TS_REG_CONTROL,
    RegStatus     = `TS_REG_STATUS,
    RegPolarity   = `TS_REG_POLARITY,
    RegVersion    = `TS_REG_VERSION,
    RegCableDelay = `TS_REG_CABLE_DELAY,
    RegIrq        = `TS_REG_IRQ,
    RegIrqMask    = `TS_REG_IRQ_MASK,
    RegEvtCount   = `TS_REG_EVT_COUNT,
    RegCount      = `TS_REG_COUNT,
    RegTimeLow    = `TS_REG_TIME_LOW,
    RegTimeHigh   = `TS_REG_TIME_HIGH
  } regAddrT;

  typedef enum logic [1:0] {
    RespOkay   = 2'b00,
    RespSlvErr = 2'b10
  } axiRespT;

endpackage

`default_nettype wire

// ==== rtl/timeFormatPkg.sv ====
// ********************
// time-of-day types
// seconds, nanoseconds and cable delay values
// ********************
`default_nettype none
`include "timestamper_consts.svh"

package timeFormatPkg;

  // seconds part of the running time
  typedef logic [`TS_SECOND_WIDTH-1:0] secondT;

  // nanoseconds part, always below one billion
  typedef logic [`TS_NANOSECOND_WIDTH-1:0] nanosecondT;

  // programmable cable delay in ns
  typedef logic [`TS_CABLE_DELAY_WIDTH-1:0] cableDelayT;

endpackage

`default_nettype wire

// ==== rtl/timestamper_consts.svh ====
// ********************
// signal timestamper constants
// widths, register offsets and masks, delays and version
// ********************
`ifndef TIMESTAMPER_CONSTS_SVH
`define TIMESTAMPER_CONSTS_SVH

// time-of-day format
`define TS_SECOND_WIDTH      32
`define TS_NANOSECOND_WIDTH  32
`define TS_NS_PER_SECOND     32'd1000000000

// delay compensation, all in ns unless counted in cycles
`define TS_CLOCK_PERIOD_NS   32'd20
`define TS_INPUT_DELAY_NS    32'd100
`define TS_SYNC_CYCLES       32'd3
`define TS_CABLE_DELAY_WIDTH 16

// AXI4-Lite bus
`define TS_AXI_ADDR_WIDTH    16
`define TS_AXI_DATA_WIDTH    32
`define TS_VERSION           32'h00010000

// register offsets
`define TS_REG_CONTROL       16'h0000
`define TS_REG_STATUS        16'h0004
`define TS_REG_POLARITY      16'h0008
`define TS_REG_VERSION       16'h000C
`define TS_REG_CABLE_DELAY   16'h0020
`define TS_REG_IRQ           16'h0030
`define TS_REG_IRQ_MASK      16'h0034
`define TS_REG_EVT_COUNT     16'h0038
`define TS_REG_COUNT         16'h0040
`define TS_REG_TIME_LOW      16'h0044
`define TS_REG_TIME_HIGH     16'h0048

// writable bits per register
`define TS_MASK_SINGLE_BIT   32'h00000001
`define TS_MASK_CABLE_DELAY  32'h0000FFFF

`endif
